// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - files:
      - src/cpuPkg.sv
      - src/cpuControl.sv
      - src/instrDecode.sv
      - src/regFile.sv
      - src/execUnit.sv
      - src/memAccess.sv
      - src/cpuTop.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/cpuTb.sv

// ==== sim.f ====
+incdir+verif
src/cpuPkg.sv
src/cpuControl.sv
src/instrDecode.sv
src/regFile.sv
src/execUnit.sv
src/memAccess.sv
src/cpuTop.sv
verif/cpuTb.sv

// ==== src/cpuControl.sv ====
`timescale 1ns/1ps

module cpuControl (
  input  logic          clk,
  input  logic          reset,
  input  logic          hasConst, // Instruction has a second word
  input  logic          isMem,    // Instruction touches data RAM
  input  cpuPkg::wordT  nextIp,
  output cpuPkg::stateE state,
  output cpuPkg::wordT  ip
);

  cpuPkg::stateE stateNext;

  // Sequence of one instruction
  always_comb begin
    stateNext = state;
    case (state)
      cpuPkg::Fetch:     stateNext = cpuPkg::FetchWait;
      cpuPkg::FetchWait: stateNext = cpuPkg::Decode;
      cpuPkg::Decode:    stateNext = cpuPkg::RegRead;
      cpuPkg::RegRead: begin
        if (hasConst)
          stateNext = cpuPkg::ConstWait; // Constant read already issued
        else if (isMem)
          stateNext = cpuPkg::MemReq;
        else
          stateNext = cpuPkg::Execute;
      end
      cpuPkg::ConstWait: stateNext = cpuPkg::ConstDone;
      cpuPkg::ConstDone: stateNext = isMem ? cpuPkg::MemReq : cpuPkg::Execute;
      cpuPkg::MemReq:    stateNext = cpuPkg::MemWait;
      cpuPkg::MemWait:   stateNext = cpuPkg::MemDone;
      cpuPkg::MemDone:   stateNext = cpuPkg::Execute;
      cpuPkg::Execute:   stateNext = cpuPkg::Fetch;
      default:           stateNext = cpuPkg::Fetch; // Recover from a bad encoding
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= cpuPkg::Fetch;
    end else begin
      state <= stateNext;
    end
  end

  // Instruction pointer moves only at the end of an instruction
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ip <= '0;
    end else if (state == cpuPkg::Execute) begin
      ip <= nextIp; // Branch target, same ip on Stall, or next word
    end
  end

  // Sequencer stays inside the ten defined states
  stateLegal: assert property (
    @(posedge clk) disable iff (reset)
    state inside {cpuPkg::Fetch, cpuPkg::FetchWait, cpuPkg::Decode, cpuPkg::RegRead,
                  cpuPkg::ConstWait, cpuPkg::ConstDone, cpuPkg::MemReq,
                  cpuPkg::MemWait, cpuPkg::MemDone, cpuPkg::Execute}
  );

endmodule

// ==== src/cpuPkg.sv ====
package cpuPkg;

  typedef logic [31:0] wordT; // Data and address word

  // Opcode byte, low byte of each instruction word
  typedef enum logic [7:0] {
    MovRC   = 8'h01, MovRR   = 8'h02,
    AddRRR  = 8'h03, AddRRC  = 8'h04, SubRRR = 8'h05, SubRRC = 8'h06,
    IncR    = 8'h07, DecR    = 8'h08, ShlRRR = 8'h09, ShrRRR = 8'h0a,
    NegRR   = 8'h0b,
    CmpRR   = 8'h0c, CmpRC   = 8'h0d,
    JmpC    = 8'h0e, JeC     = 8'h0f, JneC   = 8'h10, JzRC   = 8'h11,
    JnzRC   = 8'h12,
    MovRdC  = 8'h13, MovRdRo = 8'h14, MovdCR = 8'h15, MovdRoR = 8'h16,
    PushR   = 8'h17, PopR    = 8'h18,
    DoutR   = 8'h19, Stall   = 8'h1a
  } opcodeE;

  // Instruction sequencer states
  typedef enum logic [3:0] {
    Fetch, FetchWait, Decode, RegRead, // Every instruction
    ConstWait, ConstDone,              // Second word at ip+4
    MemReq, MemWait, MemDone,          // Data access
    Execute
  } stateE;

  // Instruction word, opcode in the low byte
  typedef struct packed {
    logic [7:0] regC;
    logic [7:0] regB;
    logic [7:0] regA;
    opcodeE     opcode;
  } instrT;

  // RAM request, 66 bits
  typedef struct packed {
    wordT addr;
    wordT wdata;
    logic read;
    logic write;
  } ramReqT;

  localparam int SpReg    = 0; // Stack pointer
  localparam int FlagsReg = 1; // Compare flags

  // Opcodes followed by a constant word
  function automatic logic is8Byte(opcodeE op);
    return op inside {MovRC, AddRRC, SubRRC, CmpRC, JmpC, JeC, JneC, JzRC, JnzRC,
                      MovRdC, MovRdRo, MovdCR, MovdRoR};
  endfunction

  // Opcodes with a data access
  function automatic logic isMemOp(opcodeE op);
    return op inside {MovRdC, MovRdRo, MovdCR, MovdRoR, PushR, PopR};
  endfunction

endpackage

// ==== src/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop #(
  parameter int NumRegs = 16 // 16 or 32
) (
  input  logic           clk,
  input  logic           reset,
  input  cpuPkg::wordT   ramIn,
  output cpuPkg::ramReqT ram,
  output cpuPkg::wordT   debugOut,
  output logic           debugValid
);

  cpuPkg::stateE state;
  cpuPkg::wordT  ip, nextIp;
  cpuPkg::instrT instr;
  cpuPkg::wordT  constWord;
  logic          hasConst, isMem;
  cpuPkg::wordT  valA, valB, valC; // Operand snapshots
  cpuPkg::wordT  sp, flags;
  cpuPkg::wordT  result, flagsNext, loadValue;
  logic          resultWe, flagsWe;
  logic          spInc, spDec;

  cpuControl control (
    .clk(clk), .reset(reset), .hasConst(hasConst), .isMem(isMem),
    .nextIp(nextIp), .state(state), .ip(ip)
  );

  instrDecode #(.NumRegs(NumRegs)) decode (
    .clk(clk), .reset(reset), .state(state), .ramIn(ramIn),
    .instr(instr), .constWord(constWord), .hasConst(hasConst), .isMem(isMem)
  );

  regFile #(.NumRegs(NumRegs)) regs (
    .clk(clk), .reset(reset), .state(state), .instr(instr),
    .result(result), .flagsNext(flagsNext), .resultWe(resultWe), .flagsWe(flagsWe),
    .spInc(spInc), .spDec(spDec),
    .valA(valA), .valB(valB), .valC(valC), .sp(sp), .flags(flags)
  );

  execUnit exec (
    .state(state), .instr(instr), .valA(valA), .valB(valB), .valC(valC),
    .constWord(constWord), .loadValue(loadValue), .flags(flags), .ip(ip),
    .result(result), .flagsNext(flagsNext), .nextIp(nextIp),
    .resultWe(resultWe), .flagsWe(flagsWe)
  );

  memAccess mem (
    .clk(clk), .reset(reset), .state(state), .instr(instr), .ip(ip),
    .valA(valA), .valB(valB), .sp(sp), .constWord(constWord), .ramIn(ramIn),
    .ram(ram), .loadValue(loadValue), .debugOut(debugOut), .debugValid(debugValid),
    .spInc(spInc), .spDec(spDec)
  );

endmodule

// ==== src/execUnit.sv ====
`timescale 1ns/1ps

module execUnit (
  input  cpuPkg::stateE state,
  input  cpuPkg::instrT instr,
  input  cpuPkg::wordT  valA,
  input  cpuPkg::wordT  valB,
  input  cpuPkg::wordT  valC,
  input  cpuPkg::wordT  constWord,
  input  cpuPkg::wordT  loadValue, // From MemDone
  input  cpuPkg::wordT  flags,
  input  cpuPkg::wordT  ip,
  output cpuPkg::wordT  result,
  output cpuPkg::wordT  flagsNext,
  output cpuPkg::wordT  nextIp,
  output logic          resultWe,
  output logic          flagsWe
);

  cpuPkg::wordT cmpRhs;
  logic         writesReg;
  logic         taken;

  always_comb begin
    case (instr.opcode)
      cpuPkg::MovRC:   result = constWord;
      cpuPkg::MovRR:   result = valB;
      cpuPkg::AddRRR:  result = valB + valC;
      cpuPkg::AddRRC:  result = valB + constWord;
      cpuPkg::SubRRR:  result = valB - valC;
      cpuPkg::SubRRC:  result = valB - constWord;
      cpuPkg::IncR:    result = valA + 32'd1;
      cpuPkg::DecR:    result = valA - 32'd1;
      cpuPkg::ShlRRR:  result = valB << valC;
      cpuPkg::ShrRRR:  result = valB >> valC; // Logical
      cpuPkg::NegRR:   result = -valB;
      default:         result = loadValue;    // Loads and pop
    endcase
  end

  assign writesReg = instr.opcode inside {
    cpuPkg::MovRC, cpuPkg::MovRR, cpuPkg::AddRRR, cpuPkg::AddRRC, cpuPkg::SubRRR,
    cpuPkg::SubRRC, cpuPkg::IncR, cpuPkg::DecR, cpuPkg::ShlRRR, cpuPkg::ShrRRR,
    cpuPkg::NegRR, cpuPkg::MovRdC, cpuPkg::MovRdRo, cpuPkg::PopR};
  assign resultWe = (state == cpuPkg::Execute) && writesReg;

  // Unsigned compare, upper flag bits kept
  assign cmpRhs    = (instr.opcode == cpuPkg::CmpRC) ? constWord : valB;
  assign flagsNext = {flags[31:3], valA > cmpRhs, valA < cmpRhs, valA == cmpRhs};
  assign flagsWe   = (state == cpuPkg::Execute) &&
                     (instr.opcode inside {cpuPkg::CmpRR, cpuPkg::CmpRC});

  always_comb begin
    case (instr.opcode)
      cpuPkg::JmpC:  taken = 1'b1;
      cpuPkg::JeC:   taken = flags[0];  // Equal
      cpuPkg::JneC:  taken = !flags[0];
      cpuPkg::JzRC:  taken = (valC == '0);
      cpuPkg::JnzRC: taken = (valC != '0);
      default:       taken = 1'b0;
    endcase
  end

  assign nextIp = taken                           ? constWord :
                  (instr.opcode == cpuPkg::Stall) ? ip :
                  ip + (cpuPkg::is8Byte(instr.opcode) ? 32'd8 : 32'd4);

endmodule

// ==== src/instrDecode.sv ====
`timescale 1ns/1ps

module instrDecode #(
  parameter int NumRegs = 16
) (
  input  logic          clk,
  input  logic          reset,
  input  cpuPkg::stateE state,
  input  cpuPkg::wordT  ramIn,
  output cpuPkg::instrT instr,
  output cpuPkg::wordT  constWord,
  output logic          hasConst,
  output logic          isMem
);

  // Keeps register bytes inside the register file
  localparam logic [7:0] RegMask = 8'(NumRegs - 1);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      instr <= '0;
    end else if (state == cpuPkg::Decode) begin
      instr <= cpuPkg::instrT'(ramIn & {RegMask, RegMask, RegMask, 8'hff});
    end
  end

  // Second word of 8-byte instructions
  always_ff @(posedge clk) begin
    if (state == cpuPkg::ConstDone) begin
      constWord <= ramIn;
    end
  end

  // Unknown opcodes fall in neither class
  assign hasConst = cpuPkg::is8Byte(instr.opcode);
  assign isMem    = cpuPkg::isMemOp(instr.opcode);

endmodule

// ==== src/memAccess.sv ====
`timescale 1ns/1ps

module memAccess (
  input  logic           clk,
  input  logic           reset,
  input  cpuPkg::stateE  state,
  input  cpuPkg::instrT  instr,
  input  cpuPkg::wordT   ip,
  input  cpuPkg::wordT   valA,
  input  cpuPkg::wordT   valB,
  input  cpuPkg::wordT   sp,
  input  cpuPkg::wordT   constWord,
  input  cpuPkg::wordT   ramIn,
  output cpuPkg::ramReqT ram,
  output cpuPkg::wordT   loadValue,
  output cpuPkg::wordT   debugOut,
  output logic           debugValid,
  output logic           spInc,
  output logic           spDec
);

  cpuPkg::ramReqT reqNext;
  cpuPkg::wordT   reqAddr, reqWdata, debugReg;
  logic           reqRead, reqWrite;

  // Request for the coming cycle, strobe lands one state later
  always_comb begin
    reqNext = '{addr: ip, wdata: valB, read: 1'b0, write: 1'b0};
    case (state)
      cpuPkg::Fetch: reqNext.read = 1'b1;
      cpuPkg::RegRead: begin
        reqNext.addr = ip + 32'd4;
        reqNext.read = cpuPkg::is8Byte(instr.opcode);
      end
      cpuPkg::MemReq: begin
        case (instr.opcode)
          cpuPkg::MovRdC:  reqNext = '{constWord, valB, 1'b1, 1'b0};
          cpuPkg::MovRdRo: reqNext = '{valB + constWord, valB, 1'b1, 1'b0};
          cpuPkg::MovdCR:  reqNext = '{constWord, valB, 1'b0, 1'b1};
          cpuPkg::MovdRoR: reqNext = '{valA + constWord, valB, 1'b0, 1'b1};
          cpuPkg::PushR:   reqNext = '{sp, valA, 1'b0, 1'b1};
          cpuPkg::PopR:    reqNext = '{sp - 32'd4, valB, 1'b1, 1'b0}; // Top of stack
          default:         reqNext = reqNext;
        endcase
      end
      default: reqNext = reqNext;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reqRead  <= 1'b0;
      reqWrite <= 1'b0;
      debugReg <= '0;
    end else begin
      reqRead  <= reqNext.read;
      reqWrite <= reqNext.write;
      if (debugValid) debugReg <= valA; // Hold last shown value
    end
  end

  always_ff @(posedge clk) begin
    reqAddr  <= reqNext.addr;
    reqWdata <= reqNext.wdata;
    if (state == cpuPkg::MemDone) loadValue <= ramIn; // Two edges after the strobe
  end

  assign ram = '{addr: reqAddr, wdata: reqWdata, read: reqRead, write: reqWrite};

  assign debugValid = (state == cpuPkg::Execute) && (instr.opcode == cpuPkg::DoutR);
  assign debugOut   = debugValid ? valA : debugReg;
  assign spInc      = (state == cpuPkg::Execute) && (instr.opcode == cpuPkg::PushR);
  assign spDec      = (state == cpuPkg::Execute) && (instr.opcode == cpuPkg::PopR);

  strobeExclusive: assert property (@(posedge clk) disable iff (reset) !(reqRead && reqWrite));
  readOneCycle: assert property (@(posedge clk) disable iff (reset) reqRead |=> !reqRead);
  writeOneCycle: assert property (@(posedge clk) disable iff (reset) reqWrite |=> !reqWrite);

  // Strobes only in the wait states of the sequencer
  strobeInWait: assert property (
    @(posedge clk) disable iff (reset)
    (reqRead || reqWrite) |-> state inside {cpuPkg::FetchWait, cpuPkg::ConstWait,
                                            cpuPkg::MemWait}
  );

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile #(
  parameter int NumRegs = 16
) (
  input  logic          clk,
  input  logic          reset,
  input  cpuPkg::stateE state,
  input  cpuPkg::instrT instr,
  input  cpuPkg::wordT  result,
  input  cpuPkg::wordT  flagsNext,
  input  logic          resultWe,
  input  logic          flagsWe,
  input  logic          spInc, // Push
  input  logic          spDec, // Pop
  output cpuPkg::wordT  valA,
  output cpuPkg::wordT  valB,
  output cpuPkg::wordT  valC,
  output cpuPkg::wordT  sp,
  output cpuPkg::wordT  flags
);

  localparam int IdxW = $clog2(NumRegs);

  cpuPkg::wordT regs [NumRegs];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < NumRegs; i++) regs[i] <= '0;
    end else if (state == cpuPkg::Execute) begin
      if (resultWe) regs[instr.regA[IdxW-1:0]] <= result;
      if (flagsWe) regs[cpuPkg::FlagsReg] <= flagsNext;
      if (spInc) regs[cpuPkg::SpReg] <= regs[cpuPkg::SpReg] + 32'd4;
      else if (spDec) regs[cpuPkg::SpReg] <= regs[cpuPkg::SpReg] - 32'd4;
    end
  end

  // Operand snapshot, held until the next instruction
  always_ff @(posedge clk) begin
    if (state == cpuPkg::RegRead) begin
      valA <= regs[instr.regA[IdxW-1:0]];
      valB <= regs[instr.regB[IdxW-1:0]];
      valC <= regs[instr.regC[IdxW-1:0]];
    end
  end

  assign sp    = regs[cpuPkg::SpReg];
  assign flags = regs[cpuPkg::FlagsReg];

  spOneWay: assert property (@(posedge clk) disable iff (reset) !(spInc && spDec));

endmodule

// ==== verif/tbProgram.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int NumDebug  = 17;
localparam int NumStores = 3;

logic [31:0] expDebug [NumDebug];
logic [31:0] expStoreAddr [NumStores];
logic [31:0] expStoreData [NumStores];
int          pc; // Word index while placing code

function automatic logic [31:0] encode(cpuPkg::opcodeE op, int a, int b, int c);
  return {8'(c), 8'(b), 8'(a), 8'(op)};
endfunction

task automatic shortInstr(cpuPkg::opcodeE op, int a, int b, int c);
  mem[pc] = encode(op, a, b, c);
  pc++;
endtask

task automatic longInstr(cpuPkg::opcodeE op, int a, int b, int c, logic [31:0] k);
  mem[pc]     = encode(op, a, b, c);
  mem[pc + 1] = k; // Constant word
  pc += 2;
endtask

task automatic loadProgram(logic [31:0] rw);
  for (int i = 0; i < 256; i++) mem[i] = 32'h5a5a_0000 ^ (i * 32'h0101_0107);
  pc = 0;
  longInstr(cpuPkg::MovRC, 2, 0, 0, 32'h1234);        // 0x00
  shortInstr(cpuPkg::DoutR, 2, 0, 0);
  longInstr(cpuPkg::MovRC, 3, 0, 0, 32'h11);
  shortInstr(cpuPkg::AddRRR, 4, 2, 3);                // 0x14
  shortInstr(cpuPkg::DoutR, 4, 0, 0);
  longInstr(cpuPkg::SubRRC, 5, 4, 0, 32'h45);
  shortInstr(cpuPkg::DoutR, 5, 0, 0);
  longInstr(cpuPkg::MovRC, 6, 0, 0, 32'd4);           // Shift amount
  shortInstr(cpuPkg::ShlRRR, 7, 2, 6);                // 0x30
  shortInstr(cpuPkg::DoutR, 7, 0, 0);
  shortInstr(cpuPkg::ShrRRR, 7, 2, 6);
  shortInstr(cpuPkg::DoutR, 7, 0, 0);
  shortInstr(cpuPkg::NegRR, 7, 3, 0);                 // 0x40
  shortInstr(cpuPkg::DoutR, 7, 0, 0);
  shortInstr(cpuPkg::IncR, 7, 0, 0);
  shortInstr(cpuPkg::DoutR, 7, 0, 0);
  shortInstr(cpuPkg::DecR, 2, 0, 0);                  // 0x50
  shortInstr(cpuPkg::DoutR, 2, 0, 0);
  longInstr(cpuPkg::MovdCR, 0, 4, 0, 32'h300);        // Store 0
  longInstr(cpuPkg::MovdRoR, 6, 5, 0, 32'h300);       // Store 1 at 0x304
  longInstr(cpuPkg::MovRdC, 8, 0, 0, 32'h380);        // 0x68 loads the random word
  shortInstr(cpuPkg::DoutR, 8, 0, 0);
  longInstr(cpuPkg::MovRdRo, 9, 6, 0, 32'h384);       // Loads 0x388
  shortInstr(cpuPkg::DoutR, 9, 0, 0);
  longInstr(cpuPkg::MovRC, 0, 0, 0, 32'h3c0);         // 0x80 sets SP
  shortInstr(cpuPkg::PushR, 2, 0, 0);                 // Store 2
  shortInstr(cpuPkg::PopR, 10, 0, 0);
  shortInstr(cpuPkg::DoutR, 10, 0, 0);                // 0x90
  shortInstr(cpuPkg::DoutR, 0, 0, 0);                 // SP back at 0x3c0
  longInstr(cpuPkg::MovRC, 11, 0, 0, 32'd3);          // Loop count
  shortInstr(cpuPkg::DoutR, 11, 0, 0);                // Loop top at 0xa0
  shortInstr(cpuPkg::DecR, 11, 0, 0);
  longInstr(cpuPkg::JnzRC, 0, 0, 11, 32'ha0);         // 0xa8
  longInstr(cpuPkg::CmpRC, 2, 0, 0, 32'h1233);        // 0xb0 compares equal
  longInstr(cpuPkg::JeC, 0, 0, 0, 32'hc4);
  shortInstr(cpuPkg::DoutR, 7, 0, 0);                 // Poison at 0xc0
  longInstr(cpuPkg::CmpRC, 2, 0, 0, 32'd5);           // 0xc4 compares greater
  longInstr(cpuPkg::JneC, 0, 0, 0, 32'hd8);
  shortInstr(cpuPkg::DoutR, 7, 0, 0);                 // Poison at 0xd4
  longInstr(cpuPkg::JeC, 0, 0, 0, 32'hd4);            // 0xd8 falls through
  shortInstr(cpuPkg::DoutR, 1, 0, 0);                 // Flags
  longInstr(cpuPkg::JmpC, 0, 0, 0, 32'hf0);           // 0xe4
  shortInstr(cpuPkg::DoutR, 7, 0, 0);                 // Poison at 0xec
  shortInstr(cpuPkg::DoutR, 9, 0, 0);                 // 0xf0
  shortInstr(cpuPkg::Stall, 0, 0, 0);
  shortInstr(cpuPkg::DoutR, 7, 0, 0);                 // Reached only if Stall moves ip
  mem[32'h380 >> 2] = rw;
  mem[32'h388 >> 2] = 32'ha5c3_0f96;
  expDebug = '{32'h1234, 32'h1234 + 32'h11, 32'h1234 + 32'h11 - 32'h45,
               32'h1234 << 4, 32'h1234 >> 4, -32'h11, -32'h11 + 32'd1, 32'h1233,
               rw, 32'ha5c3_0f96, 32'h1233, 32'h3c0, 32'd3, 32'd2, 32'd1,
               32'b100, 32'ha5c3_0f96};
  expStoreAddr = '{32'h300, 32'h304, 32'h3c0};
  expStoreData = '{32'h1245, 32'h1200, 32'h1233};
endtask

`endif

// ==== verif/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

  logic           clk;
  logic           reset;
  cpuPkg::wordT   ramIn;
  cpuPkg::ramReqT ram;
  cpuPkg::wordT   debugOut;
  logic           debugValid;

  logic [31:0] mem [256];  // 1 KiB word RAM
  logic [15:0] lfsrState;
  logic [31:0] randWord;   // Loaded by MovRdC

  int  debugCount, storeCount;
  int  cycle, nextFetch;   // Cycle of the next expected fetch strobe
  logic seenFetch;
  int  debugErrors, storeErrors, timingErrors;
  logic timedOut;

  `include "tbProgram.svh"

  cpuTop #(.NumRegs(16)) dut (
    .clk(clk), .reset(reset), .ramIn(ramIn), .ram(ram),
    .debugOut(debugOut), .debugValid(debugValid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrStep(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [31:0] randomWord();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsrState = lfsrStep(lfsrState); // One step per bit
      w = {w[30:0], lfsrState[0]};
    end
    return w;
  endfunction

  // Cycles between fetch strobes by instruction class
  function automatic int fetchGap(logic [7:0] op);
    logic longOp, memOp;
    longOp = op inside {cpuPkg::MovRC, cpuPkg::AddRRC, cpuPkg::SubRRC, cpuPkg::CmpRC,
                        cpuPkg::JmpC, cpuPkg::JeC, cpuPkg::JneC, cpuPkg::JzRC,
                        cpuPkg::JnzRC, cpuPkg::MovRdC, cpuPkg::MovRdRo, cpuPkg::MovdCR,
                        cpuPkg::MovdRoR};
    memOp = op inside {cpuPkg::MovRdC, cpuPkg::MovRdRo, cpuPkg::MovdCR, cpuPkg::MovdRoR,
                       cpuPkg::PushR, cpuPkg::PopR};
    return 5 + (longOp ? 2 : 0) + (memOp ? 3 : 0);
  endfunction

  // RAM model, data lands 1 ns after the sampling edge
  always @(posedge clk) begin
    if (ram.write) mem[ram.addr[9:2]] <= ram.wdata;
    if (ram.read) ramIn <= #1 mem[ram.addr[9:2]];
  end

  // Output counters and fetch tracking
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      debugCount <= 0;
      storeCount <= 0;
      cycle      <= 0;
      nextFetch  <= 0;
      seenFetch  <= 1'b0;
    end else begin
      cycle <= cycle + 1;
      if (debugValid) debugCount <= debugCount + 1;
      if (ram.write) storeCount <= storeCount + 1;
      if (ram.read && (!seenFetch || cycle == nextFetch)) begin
        seenFetch <= 1'b1;
        nextFetch <= cycle + fetchGap(mem[ram.addr[9:2]][7:0]); // Opcode byte
      end
    end
  end

  debugValue: assert property (@(posedge clk) disable iff (reset)
    debugValid && debugCount < NumDebug |-> debugOut == expDebug[debugCount])
    else begin
      debugErrors++;
      $display("Error at %0t: debugOut expected %h, got %h", $time,
               expDebug[$sampled(debugCount)], $sampled(debugOut));
    end

  debugExtra: assert property (@(posedge clk) disable iff (reset)
    debugValid |-> debugCount < NumDebug)
    else begin
      debugErrors++;
      $display("Unexpected extra debug output at %0t", $time);
    end

  storeAddr: assert property (@(posedge clk) disable iff (reset)
    ram.write && storeCount < NumStores |-> ram.addr == expStoreAddr[storeCount])
    else begin
      storeErrors++;
      $display("Error at %0t: ram.addr expected %h, got %h", $time,
               expStoreAddr[$sampled(storeCount)], $sampled(ram.addr));
    end

  storeData: assert property (@(posedge clk) disable iff (reset)
    ram.write && storeCount < NumStores |-> ram.wdata == expStoreData[storeCount])
    else begin
      storeErrors++;
      $display("Error at %0t: ram.wdata expected %h, got %h", $time,
               expStoreData[$sampled(storeCount)], $sampled(ram.wdata));
    end

  storeExtra: assert property (@(posedge clk) disable iff (reset)
    ram.write |-> storeCount < NumStores)
    else begin
      storeErrors++;
      $display("Unexpected extra RAM write at %0t", $time);
    end

  firstFetch: assert property (@(posedge clk) disable iff (reset) !seenFetch |-> cycle <= 2)
    else begin
      timingErrors++;
      $display("First fetch did not come within 2 cycles of reset at %0t", $time);
    end

  fetchOnTime: assert property (@(posedge clk) disable iff (reset)
    seenFetch && cycle == nextFetch |-> ram.read)
    else begin
      timingErrors++;
      $display("Fetch strobe missing at %0t, cycle %0d", $time, $sampled(cycle));
    end

  noOverlap: assert property (@(posedge clk) disable iff (reset) !(ram.read && ram.write))
    else begin
      timingErrors++;
      $display("Read and write strobes high together at %0t", $time);
    end

  readPulse: assert property (@(posedge clk) disable iff (reset) ram.read |=> !ram.read)
    else begin
      timingErrors++;
      $display("Read strobe longer than one cycle at %0t", $time);
    end

  writePulse: assert property (@(posedge clk) disable iff (reset) ram.write |=> !ram.write)
    else begin
      timingErrors++;
      $display("Write strobe longer than one cycle at %0t", $time);
    end

  initial begin
    int waitCycles;
    reset        = 1'b1;
    ramIn        = '0;
    debugErrors  = 0;
    storeErrors  = 0;
    timingErrors = 0;
    timedOut     = 1'b0;
    lfsrState    = 16'd36431;
    randWord     = randomWord();
    loadProgram(randWord);
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
    waitCycles = 0;
    while (debugCount < NumDebug && waitCycles < 2000) begin
      @(posedge clk);
      waitCycles++;
    end
    if (debugCount < NumDebug) begin
      timedOut = 1'b1;
      $display("Timed out after %0d cycles with %0d of %0d debug outputs", waitCycles,
               debugCount, NumDebug);
    end
    waitCycles = 0;
    while (waitCycles < 40) begin  // Quiet window on the Stall loop
      @(posedge clk);
      waitCycles++;
    end
    if (storeCount != NumStores) begin
      storeErrors++;
      $display("Saw %0d RAM writes where %0d were expected", storeCount, NumStores);
    end
    $display("Error counts: debug %0d, store %0d, timing %0d", debugErrors, storeErrors,
             timingErrors);
    if (!timedOut && debugErrors == 0 && storeErrors == 0 && timingErrors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
